// File: filelist.f
+incdir+include
hdl/multicore_pkg.sv
hdl/reset_sequencer.sv
hdl/program_rom.sv
hdl/rede_core.sv
hdl/output_select.sv
hdl/multicore.sv
tb/multicore_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module multicore_tb \
	-f filelist.f

sim_out=$(./obj_dir/Vmulticore_tb)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi

echo "run_sim.sh: the testbench did not report a pass"
exit 1

// File: tb/multicore_tb.sv
`timescale 1ns/1ps
`include "multicore_settings.svh"

module multicore_tb import multicore_pkg::*; ();

	localparam int PERIOD          = 40;
	localparam int RESET_CYCLES    = 5;
	localparam int N               = `NUM_CORES;
	localparam int GAP             = `RELEASE_GAP;
	localparam int LOOP_LEN        = `PROG_LEN;
	localparam int LAST_REQ        = 2 + (N - 1) * GAP;
	localparam int HIST_LEN        = 1024;
	localparam int WATCHDOG_CYCLES = N * GAP + 200;

	logic                      clk;
	logic                      rst_n;
	logic signed [`DATA_W-1:0] io_in;
	core_out_t [N-1:0]         core_outs;
	port_t [N-1:0]             req_ins;
	logic signed [`DATA_W-1:0] io_out;
	port_t                     out_en;
	logic [3:0]                out_core;

	int                        cyc; // edges since rst_n was last sampled high.
	logic signed [`DATA_W-1:0] in_hist [HIST_LEN];
	int                        checks;
	int                        mismatches;
	int                        failures;

	multicore multicore_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.io_in    (io_in),
		.core_outs(core_outs),
		.req_ins  (req_ins),
		.io_out   (io_out),
		.out_en   (out_en),
		.out_core (out_core)
	);

	//////////////////////////////////////////////////////////////////////
	// clock, stimulus and input history

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic signed [`DATA_W-1:0] draw_input();
		logic [31:0] r;
		r = $urandom;
		case (r[31:28])
			4'd0: return {1'b0, {(`DATA_W - 1){1'b1}}}; // largest positive value.
			4'd1: return {1'b1, {(`DATA_W - 1){1'b0}}}; // most negative value.
			default: return r[`DATA_W-1:0];
		endcase
	endfunction

	always @(posedge clk) begin
		#2;
		io_in = draw_input();
	end

	// The value of io_in at each edge of the run is what a core would latch there.
	always @(posedge clk) begin
		if (!rst_n) begin
			cyc = -1;
		end else begin
			cyc = cyc + 1;
			if (cyc < HIST_LEN) begin
				in_hist[cyc] = io_in;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference model

	// core k is released at edge 1 + k * gap and runs its first input one edge later.
	function automatic int first_req_cycle(input int k);
		return 2 + k * GAP;
	endfunction

	function automatic logic signed [`DATA_W-1:0] wrap_data(input longint x);
		return x[`DATA_W-1:0];
	endfunction

	function automatic port_t expected_req(input int k, input int c);
		int d;
		d = c - first_req_cycle(k);
		if (d >= 0 && (d % LOOP_LEN) == 0) begin
			return port_t'(`IN_PORT);
		end
		return PORT_NONE;
	endfunction

	function automatic core_out_t expected_out(input int k, input int c);
		core_out_t o;
		int        d;
		o = '0;
		d = c - first_req_cycle(k);
		if (d >= 0 && (d % LOOP_LEN) == 2) begin
			o.data   = wrap_data(longint'(in_hist[c - 2]) * `MUL_CONST);
			o.out_en = port_t'(`OUT_PORT_A);
		end else if (d >= 0 && (d % LOOP_LEN) == 4) begin
			o.data   = wrap_data(longint'(in_hist[c - 4]) * `MUL_CONST + `ADD_CONST);
			o.out_en = port_t'(`OUT_PORT_B);
		end
		return o;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checking helpers

	task automatic expect_value(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			mismatches++;
			$display("Mismatch at %0d ns: %s", $time, msg);
		end
	endtask

	task automatic expect_event(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			failures++;
			$display("Failure at %0d ns: %s", $time, msg);
		end
	endtask

	task automatic outputs_idle(input string tag);
		expect_value(req_ins == '0 && core_outs == '0 && out_en == PORT_NONE &&
			io_out == '0 && out_core == 4'd0,
			$sformatf("%s: outputs not idle, out_en %0d io_out %0d out_core %0d",
				tag, out_en, io_out, out_core));
	endtask

	task automatic compare_core(input int k);
		port_t     want_req;
		core_out_t want_out;
		want_req = expected_req(k, cyc);
		want_out = expected_out(k, cyc);
		expect_value(req_ins[k] == want_req,
			$sformatf("core %0d cycle %0d req_in %0d, expected %0d",
				k, cyc, req_ins[k], want_req));
		expect_value(core_outs[k] == want_out,
			$sformatf("core %0d cycle %0d port %0d data %0d, expected port %0d data %0d",
				k, cyc, core_outs[k].out_en, core_outs[k].data, want_out.out_en, want_out.data));
	endtask

	// the lowest-numbered core that the model has writing wins.
	task automatic compare_select();
		int         win;
		core_out_t  want;
		core_out_t  win_out;
		logic [3:0] want_core;
		win     = -1;
		win_out = '0;
		for (int k = 0; k < N; k++) begin
			want = expected_out(k, cyc);
			if (win < 0 && want.out_en != PORT_NONE) begin
				win     = k;
				win_out = want;
			end
		end
		if (win < 0) begin
			expect_value(out_en == PORT_NONE && io_out == '0 && out_core == 4'd0,
				$sformatf("cycle %0d no writer, but out_en %0d io_out %0d out_core %0d",
					cyc, out_en, io_out, out_core));
		end else begin
			want_core = 4'(win);
			expect_value(out_core == want_core && out_en == win_out.out_en &&
				io_out == win_out.data,
				$sformatf("cycle %0d selected core %0d port %0d data %0d, expected core %0d",
					cyc, out_core, out_en, io_out, win));
		end
	endtask

	task automatic apply_reset();
		if (rst_n) begin
			@(posedge clk);
			#2;
			rst_n = 1'b0;
		end
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#2;
			if (i == RESET_CYCLES - 1) begin
				rst_n = 1'b1;
			end
			@(negedge clk);
			outputs_idle("reset");
		end
	endtask

	// Watches the whole release sequence and checks the spacing of first requests.
	task automatic follow_release();
		int first_seen [N];
		for (int k = 0; k < N; k++) begin
			first_seen[k] = -1;
		end
		while (cyc < LAST_REQ + 2) begin
			@(negedge clk);
			for (int k = 0; k < N; k++) begin
				if (first_seen[k] < 0 && req_ins[k] == port_t'(`IN_PORT)) begin
					first_seen[k] = cyc;
				end else if (first_seen[k] < 0) begin
					expect_value(req_ins[k] == PORT_NONE && core_outs[k] == '0,
						$sformatf("core %0d active at cycle %0d before its release", k, cyc));
				end
				compare_core(k);
			end
			compare_select();
		end
		for (int k = 0; k < N; k++) begin
			expect_event(first_seen[k] >= 0,
				$sformatf("core %0d never requested input after reset", k));
			if (first_seen[k] >= 0 && first_seen[0] >= 0) begin
				expect_value(first_seen[k] - first_seen[0] == k * GAP,
					$sformatf("core %0d first request %0d cycles after core 0, expected %0d",
						k, first_seen[k] - first_seen[0], k * GAP));
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic reset_state();
		apply_reset();
		repeat (2) begin
			@(negedge clk);
			outputs_idle("first edges after reset");
		end
	endtask

	task automatic staggered_release();
		follow_release();
	endtask

	task automatic result_values(input int n);
		core_out_t want;
		repeat (n) begin
			@(negedge clk);
			for (int k = 0; k < N; k++) begin
				want = expected_out(k, cyc);
				if (want.out_en != PORT_NONE) begin
					expect_value(core_outs[k] == want,
						$sformatf("core %0d wrote %0d on port %0d, expected %0d on port %0d",
							k, core_outs[k].data, core_outs[k].out_en, want.data, want.out_en));
				end else begin
					expect_value(core_outs[k].out_en == PORT_NONE,
						$sformatf("core %0d wrote port %0d in cycle %0d with nothing due",
							k, core_outs[k].out_en, cyc));
				end
			end
		end
	endtask

	task automatic loop_period(input int n);
		int        reqs [N];
		int        writes [N];
		core_out_t want;
		for (int k = 0; k < N; k++) begin
			reqs[k]   = 0;
			writes[k] = 0;
		end
		repeat (n) begin
			@(negedge clk);
			for (int k = 0; k < N; k++) begin
				want = expected_out(k, cyc);
				if (req_ins[k] != PORT_NONE) reqs[k]++;
				if (core_outs[k].out_en != PORT_NONE) writes[k]++;
				expect_value(req_ins[k] == expected_req(k, cyc) &&
					core_outs[k].out_en == want.out_en,
					$sformatf("core %0d cycle %0d req %0d port %0d out of its 6-cycle loop",
						k, cyc, req_ins[k], core_outs[k].out_en));
			end
		end
		for (int k = 0; k < N; k++) begin
			expect_value(reqs[k] == n / LOOP_LEN && writes[k] == 2 * (n / LOOP_LEN),
				$sformatf("core %0d made %0d requests and %0d writes in %0d cycles",
					k, reqs[k], writes[k], n));
		end
	endtask

	task automatic priority_select(input int n);
		int writers;
		int shared;
		shared = 0;
		repeat (n) begin
			@(negedge clk);
			compare_select();
			writers = 0;
			for (int k = 0; k < N; k++) begin
				if (core_outs[k].out_en != PORT_NONE) writers++;
			end
			if (writers > 1) shared++;
		end
		expect_event(shared > 0, "no cycle with several writing cores occurred");
	endtask

	task automatic midrun_reset();
		apply_reset();
		follow_release();
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence and watchdog

	initial begin
		void'($urandom(32'h51df4f8f));
		clk        = 1'b0;
		rst_n      = 1'b0;
		io_in      = '0;
		cyc        = -1;
		checks     = 0;
		mismatches = 0;
		failures   = 0;

		reset_state();
		staggered_release();
		result_values(2 * LOOP_LEN);
		loop_period(2 * LOOP_LEN);
		priority_select(2 * LOOP_LEN);
		midrun_reset();

		$display("checks %0d, mismatches %0d, other failures %0d",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: hdl/multicore.sv
`timescale 1ns/1ps
`include "multicore_settings.svh"

module multicore import multicore_pkg::*; (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic signed [`DATA_W-1:0]  io_in,
	output core_out_t [`NUM_CORES-1:0] core_outs,
	output port_t [`NUM_CORES-1:0]     req_ins,
	output logic signed [`DATA_W-1:0]  io_out,
	output port_t                      out_en,
	output logic [3:0]                 out_core
);

	logic [`NUM_CORES-1:0] run; // per-core release from the sequencer.

	//////////////////////////////////////////////////////////////////////
	// release sequencing

	reset_sequencer seq_i (
		.clk  (clk),
		.rst_n(rst_n),
		.run  (run)
	);

	//////////////////////////////////////////////////////////////////////
	// core array

	// every core sees the same shared input level.
	for (genvar k = 0; k < `NUM_CORES; k++) begin : g_core
		rede_core core_i (
			.clk     (clk),
			.rst_n   (rst_n),
			.run     (run[k]),
			.io_in   (io_in),
			.req_in  (req_ins[k]),
			.core_out(core_outs[k])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// shared output

	output_select sel_i (
		.core_outs(core_outs),
		.io_out   (io_out),
		.out_en   (out_en),
		.out_core (out_core)
	);

endmodule

// File: hdl/output_select.sv
`timescale 1ns/1ps
`include "multicore_settings.svh"

module output_select import multicore_pkg::*; (
	input  core_out_t [`NUM_CORES-1:0] core_outs,
	output logic signed [`DATA_W-1:0]  io_out,
	output port_t                      out_en,
	output logic [3:0]                 out_core
);

	localparam int N     = `NUM_CORES;
	localparam int IDX_W = $clog2(`NUM_CORES);

	// scan from the top down so the lowest writing core ends up selected.
	always_comb begin
		io_out   = '0;
		out_en   = PORT_NONE;
		out_core = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (core_outs[i].out_en != PORT_NONE) begin
				io_out   = core_outs[i].data;
				out_en   = core_outs[i].out_en;
				out_core = 4'(i);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	// the shared output always belongs to a core that is writing now.
	always_comb begin
		if (out_en != PORT_NONE) begin
			a_src: assert #0 (core_outs[out_core[IDX_W-1:0]].out_en == out_en &&
				core_outs[out_core[IDX_W-1:0]].data == io_out);
		end
	end

endmodule

// File: hdl/rede_core.sv
`timescale 1ns/1ps
`include "multicore_settings.svh"

module rede_core import multicore_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      run,
	input  logic signed [`DATA_W-1:0] io_in,
	output port_t                     req_in,
	output core_out_t                 core_out
);

	core_state_e               state;
	logic [2:0]                pc;
	logic [2:0]                fetch_pc;
	logic signed [`DATA_W-1:0] acc;
	logic signed [`DATA_W-1:0] imm_ext;
	instr_t                    instr;

	//////////////////////////////////////////////////////////////////////
	// fetch

	// a freshly released core always starts at the top of the program.
	assign fetch_pc = (state == ST_RUN) ? pc : 3'd0;

	program_rom rom_i (
		.pc   (fetch_pc),
		.instr(instr)
	);

	assign imm_ext = `DATA_W'(instr.imm); // sign extended operand.

	//////////////////////////////////////////////////////////////////////
	// execute

	// One instruction per cycle. The port outputs are registered, so
	// during a cycle they report the instruction executed the cycle
	// before.
	always_ff @(posedge clk) begin
		if (!rst_n || !run) begin
			state    <= ST_RESET;
			pc       <= '0;
			acc      <= '0;
			req_in   <= PORT_NONE;
			core_out <= '0;
		end else begin
			state    <= ST_RUN;
			pc       <= fetch_pc + 3'd1;
			req_in   <= PORT_NONE; // strobes last one cycle.
			core_out <= '0;
			case (instr.op)
				OP_IN: begin
					acc    <= io_in;
					req_in <= instr.port;
				end
				OP_MULI: begin
					acc <= acc * imm_ext; // wraps at DATA_W bits.
				end
				OP_ADDI: begin
					acc <= acc + imm_ext;
				end
				OP_OUT: begin
					core_out.data   <= acc;
					core_out.out_en <= instr.port;
				end
				OP_JMP: begin
					pc <= instr.imm[2:0];
				end
				default: begin
					acc <= acc; // nop keeps the accumulator.
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	a_pc_range: assert property (@(posedge clk) pc < 3'(`PROG_LEN));

endmodule

// File: hdl/program_rom.sv
`timescale 1ns/1ps
`include "multicore_settings.svh"

module program_rom import multicore_pkg::*; (
	input  logic [2:0] pc,
	output instr_t     instr
);

	always_comb begin
		case (pc)
			3'd0: instr = '{op: OP_IN, port: port_t'(`IN_PORT), imm: 16'sd0};
			3'd1: instr = '{op: OP_MULI, port: PORT_NONE, imm: 16'(`MUL_CONST)};
			3'd2: instr = '{op: OP_OUT, port: port_t'(`OUT_PORT_A), imm: 16'sd0};
			3'd3: instr = '{op: OP_ADDI, port: PORT_NONE, imm: 16'(`ADD_CONST)};
			3'd4: instr = '{op: OP_OUT, port: port_t'(`OUT_PORT_B), imm: 16'sd0};
			3'd5: instr = '{op: OP_JMP, port: PORT_NONE, imm: 16'(`LOOP_TARGET)};
			default: begin
				instr = '{op: OP_NOP, port: PORT_NONE, imm: 16'sd0}; // unused addresses.
			end
		endcase
	end

endmodule

// File: hdl/reset_sequencer.sv
`timescale 1ns/1ps
`include "multicore_settings.svh"

module reset_sequencer (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic [`NUM_CORES-1:0] run
);

	localparam int N     = `NUM_CORES;
	localparam int GAP_W = $clog2(`RELEASE_GAP + 1);
	localparam int IDX_W = $clog2(`NUM_CORES + 1);

	logic [GAP_W-1:0] gap_cnt;
	logic [IDX_W-1:0] core_idx;  // next core to release.
	logic             started;
	logic             done;

	assign done = (core_idx == IDX_W'(N)); // every core is running.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			started  <= 1'b0;
			gap_cnt  <= '0;
			core_idx <= '0;
			run      <= '0;
		end else if (!started) begin
			started <= 1'b1; // first edge out of reset only arms the sequence.
		end else if (!done) begin
			if (gap_cnt == '0) begin
				run <= run | (N'(1) << core_idx);
			end
			if (gap_cnt == GAP_W'(`RELEASE_GAP - 1)) begin
				gap_cnt  <= '0;
				core_idx <= core_idx + IDX_W'(1);
			end else begin
				gap_cnt <= gap_cnt + GAP_W'(1);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks

	// a released core keeps running until the next reset.
	a_run_hold: assert property (@(posedge clk)
		rst_n |=> ((run & $past(run)) == $past(run)));

endmodule

// File: hdl/multicore_pkg.sv
`include "multicore_settings.svh"

package multicore_pkg;

	// instruction set of the accumulator core.
	typedef enum logic [2:0] {
		OP_NOP  = 3'd0,
		OP_IN   = 3'd1,
		OP_MULI = 3'd2,
		OP_ADDI = 3'd3,
		OP_OUT  = 3'd4,
		OP_JMP  = 3'd5
	} opcode_e;

	typedef enum logic {
		ST_RESET = 1'b0,
		ST_RUN   = 1'b1
	} core_state_e;

	typedef logic [3:0] port_t; // zero means no port.

	localparam port_t PORT_NONE = 4'd0;

	typedef struct packed {
		opcode_e           op;
		port_t             port;
		logic signed [15:0] imm; // immediate operand or jump target.
	} instr_t;

	typedef struct packed {
		logic signed [`DATA_W-1:0] data;
		port_t                     out_en;
	} core_out_t;

endpackage

// File: include/multicore_settings.svh
`ifndef MULTICORE_SETTINGS_SVH
`define MULTICORE_SETTINGS_SVH

// array size and release spacing.
`define NUM_CORES   8
`define RELEASE_GAP 20

// datapath width and program length.
`define DATA_W      31
`define PROG_LEN    6

// constants of the fixed program.
`define IN_PORT     1
`define MUL_CONST   3
`define ADD_CONST   7
`define OUT_PORT_A  1
`define OUT_PORT_B  2
`define LOOP_TARGET 0

`endif
